/* logic/perceptron_pkg.sv */
package perceptron_pkg;

	localparam int history_len = 12;
	localparam int index_bits = 8;
	localparam int row_count = 256;
	localparam int weight_bits = 8;
	localparam int threshold = 38;
	// 13 weights of at most 127 each fit in a signed 12-bit sum
	localparam int sum_bits = 12;
	localparam int row_bits = (history_len + 1) * weight_bits;
	localparam int weight_max = 2 ** (weight_bits - 1) - 1;

	// one table word, stored flat and used as weights; w[history_len] is the bias
	typedef union packed {
		logic [row_bits-1:0] flat;
		logic signed [history_len:0][weight_bits-1:0] w;
	} weight_row_u;

	// step one weight toward +/-weight_max, never onto -128
	function automatic logic signed [weight_bits-1:0] sat_step(
		input logic signed [weight_bits-1:0] w,
		input logic up
	);
		if (up && w < weight_max)
			return w + 8'sd1;
		if (!up && w > -weight_max)
			return w - 8'sd1;
		return w;
	endfunction

	// a set history bit adds its weight, a clear one subtracts it
	function automatic logic signed [sum_bits-1:0] row_dot(
		input weight_row_u row,
		input logic [history_len-1:0] hist
	);
		logic signed [sum_bits-1:0] acc;
		acc = $signed(row.w[history_len]);
		for (int i = 0; i < history_len; i++) begin
			if (hist[i])
				acc = acc + $signed(row.w[i]);
			else
				acc = acc - $signed(row.w[i]);
		end
		return acc;
	endfunction

endpackage

/* logic/weight_bus_if.sv */
interface weight_bus_if;

	logic req;
	logic we;
	logic [perceptron_pkg::index_bits-1:0] addr;
	perceptron_pkg::weight_row_u wdata;
	// gnt is a one-cycle pulse, rdata follows one cycle after a read grant
	logic gnt;
	perceptron_pkg::weight_row_u rdata;

	modport requester (
		output req, we, addr, wdata,
		input gnt, rdata
	);

	modport arbiter (
		input req, we, addr, wdata,
		output gnt, rdata
	);

endinterface

/* logic/weight_table.sv */
module weight_table (
	input logic clk,
	input logic arst_n,
	input logic en,
	input logic we,
	input logic [perceptron_pkg::index_bits-1:0] addr,
	input logic [perceptron_pkg::row_bits-1:0] wdata,
	output logic [perceptron_pkg::row_bits-1:0] rdata
);

	logic [perceptron_pkg::row_bits-1:0] mem [perceptron_pkg::row_count];
	// a row that was never written since reset reads as all zero weights
	logic [perceptron_pkg::row_count-1:0] valid;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			valid <= '0;
		end else if (en && we) begin
			valid[addr] <= 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (en && we) begin
			mem[addr] <= wdata;
		end
		// single registered read port
		if (en && !we) begin
			rdata <= valid[addr] ? mem[addr] : '0;
		end
	end

endmodule

/* logic/table_arbiter.sv */
module table_arbiter (
	input logic clk,
	input logic arst_n,
	weight_bus_if.arbiter train_bus,
	weight_bus_if.arbiter pred_bus,
	output logic en,
	output logic we,
	output logic [perceptron_pkg::index_bits-1:0] addr,
	output logic [perceptron_pkg::row_bits-1:0] wdata,
	input logic [perceptron_pkg::row_bits-1:0] rdata
);

	// owner of the most recent access, steers the read data one cycle later
	logic last_train;

	// training has fixed priority over prediction
	assign train_bus.gnt = train_bus.req;
	assign pred_bus.gnt = pred_bus.req && !train_bus.req;

	assign en = train_bus.req || pred_bus.req;
	assign we = train_bus.req ? train_bus.we : pred_bus.we;
	assign addr = train_bus.req ? train_bus.addr : pred_bus.addr;
	assign wdata = train_bus.req ? train_bus.wdata.flat : pred_bus.wdata.flat;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			last_train <= 1'b0;
		end else if (en) begin
			last_train <= train_bus.req;
		end
	end

	assign train_bus.rdata = last_train ? rdata : '0;
	assign pred_bus.rdata = last_train ? '0 : rdata;

	// a starved prediction keeps its request and row until the table serves it
	a_req_held: assert property (
		@(posedge clk) disable iff (!arst_n)
		(pred_bus.req && !pred_bus.gnt) |=> (pred_bus.req && $stable(pred_bus.addr))
	);

endmodule

/* logic/predict_unit.sv */
module predict_unit (
	input logic clk,
	input logic arst_n,
	input logic predict_valid,
	input logic [63:0] ip,
	input logic [perceptron_pkg::history_len-1:0] history,
	weight_bus_if.requester pred_bus,
	output logic pred_valid,
	output logic pred_taken,
	output logic signed [perceptron_pkg::sum_bits-1:0] pred_sum,
	output logic [perceptron_pkg::index_bits-1:0] rec_index,
	output logic signed [perceptron_pkg::sum_bits-1:0] rec_sum,
	output logic [perceptron_pkg::history_len-1:0] rec_history,
	output logic active
);

	logic wait_gnt;
	logic data_cyc;
	logic [perceptron_pkg::index_bits-1:0] index_q;
	logic [perceptron_pkg::history_len-1:0] hist_q;
	logic signed [perceptron_pkg::sum_bits-1:0] sum;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wait_gnt <= 1'b0;
			data_cyc <= 1'b0;
		end else begin
			// rdata shows up the cycle after our grant
			data_cyc <= wait_gnt && pred_bus.gnt;
			if (predict_valid) begin
				wait_gnt <= 1'b1;
			end else if (pred_bus.gnt) begin
				wait_gnt <= 1'b0;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (predict_valid) begin
			index_q <= ip[perceptron_pkg::index_bits-1:0];
			hist_q <= history;
		end
		// record for the next resolve
		if (data_cyc) begin
			rec_index <= index_q;
			rec_sum <= sum;
			rec_history <= hist_q;
		end
	end

	// read-only client
	assign pred_bus.req = wait_gnt;
	assign pred_bus.we = 1'b0;
	assign pred_bus.addr = index_q;
	assign pred_bus.wdata = '0;

	assign sum = perceptron_pkg::row_dot(pred_bus.rdata, hist_q);

	assign pred_valid = data_cyc;
	assign pred_sum = sum;
	// zero sum predicts not taken
	assign pred_taken = sum > 0;
	assign active = wait_gnt || data_cyc;

	a_no_overlap: assert property (
		@(posedge clk) disable iff (!arst_n)
		predict_valid |-> !active
	);

endmodule

/* logic/train_unit.sv */
module train_unit (
	input logic clk,
	input logic arst_n,
	input logic resolve_valid,
	input logic taken,
	input logic [perceptron_pkg::index_bits-1:0] rec_index,
	input logic signed [perceptron_pkg::sum_bits-1:0] rec_sum,
	input logic [perceptron_pkg::history_len-1:0] rec_history,
	weight_bus_if.requester train_bus,
	output logic [perceptron_pkg::history_len-1:0] history,
	output logic active
);

	logic rd_wait;
	logic data_cyc;
	logic wr_wait;
	logic need_train;
	logic [perceptron_pkg::sum_bits-1:0] mag;
	logic [perceptron_pkg::index_bits-1:0] idx_q;
	logic [perceptron_pkg::history_len-1:0] hist_q;
	logic outcome_q;
	perceptron_pkg::weight_row_u wrow_q;
	perceptron_pkg::weight_row_u new_row;

	// train on a mispredict or on a low-confidence sum
	always_comb begin
		mag = rec_sum[perceptron_pkg::sum_bits-1] ? -rec_sum : rec_sum;
		need_train = ((rec_sum > 0) != taken) || (mag <= perceptron_pkg::threshold);
	end

	// each weight moves toward agreement of its history bit with the outcome
	always_comb begin
		new_row = train_bus.rdata;
		for (int i = 0; i < perceptron_pkg::history_len; i++) begin
			new_row.w[i] = perceptron_pkg::sat_step(train_bus.rdata.w[i],
				hist_q[i] == outcome_q);
		end
		new_row.w[perceptron_pkg::history_len] = perceptron_pkg::sat_step(
			train_bus.rdata.w[perceptron_pkg::history_len], outcome_q);
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			rd_wait <= 1'b0;
			data_cyc <= 1'b0;
			wr_wait <= 1'b0;
			history <= '0;
		end else begin
			data_cyc <= rd_wait && train_bus.gnt;
			if (resolve_valid && need_train) begin
				rd_wait <= 1'b1;
			end else if (train_bus.gnt) begin
				rd_wait <= 1'b0;
			end
			if (data_cyc) begin
				wr_wait <= 1'b1;
			end else if (train_bus.gnt) begin
				wr_wait <= 1'b0;
			end
			// no training shifts at once, training shifts on the write grant
			if (resolve_valid && !need_train) begin
				history <= {history[perceptron_pkg::history_len-2:0], taken};
			end else if (wr_wait && train_bus.gnt) begin
				history <= {history[perceptron_pkg::history_len-2:0], outcome_q};
			end
		end
	end

	always_ff @(posedge clk) begin
		if (resolve_valid) begin
			idx_q <= rec_index;
			hist_q <= rec_history;
			outcome_q <= taken;
		end
		if (data_cyc) begin
			wrow_q <= new_row;
		end
	end

	assign train_bus.req = rd_wait || wr_wait;
	assign train_bus.we = wr_wait;
	assign train_bus.addr = idx_q;
	assign train_bus.wdata = wrow_q;
	assign active = rd_wait || data_cyc || wr_wait;

	for (genvar g = 0; g <= perceptron_pkg::history_len; g++) begin : g_range
		a_weight_range: assert property (
			@(posedge clk) disable iff (!arst_n)
			(train_bus.req && train_bus.we) |->
				$signed(train_bus.wdata.w[g]) >= -8'sd127
		);
	end

endmodule

/* logic/perceptron_predictor.sv */
module perceptron_predictor (
	input logic clk,
	input logic arst_n,
	input logic predict_valid,
	input logic [63:0] ip,
	input logic resolve_valid,
	input logic taken,
	output logic pred_valid,
	output logic pred_taken,
	output logic signed [perceptron_pkg::sum_bits-1:0] pred_sum,
	output logic busy
);

	logic [perceptron_pkg::history_len-1:0] history;
	logic [perceptron_pkg::index_bits-1:0] rec_index;
	logic signed [perceptron_pkg::sum_bits-1:0] rec_sum;
	logic [perceptron_pkg::history_len-1:0] rec_history;
	logic pred_active;
	logic train_active;
	logic tbl_en;
	logic tbl_we;
	logic [perceptron_pkg::index_bits-1:0] tbl_addr;
	logic [perceptron_pkg::row_bits-1:0] tbl_wdata;
	logic [perceptron_pkg::row_bits-1:0] tbl_rdata;

	weight_bus_if pred_bus ();
	weight_bus_if train_bus ();

	predict_unit u_predict (
		.clk, .arst_n, .predict_valid, .ip, .history, .pred_bus,
		.pred_valid, .pred_taken, .pred_sum,
		.rec_index, .rec_sum, .rec_history, .active(pred_active)
	);

	train_unit u_train (
		.clk, .arst_n, .resolve_valid, .taken,
		.rec_index, .rec_sum, .rec_history, .train_bus,
		.history, .active(train_active)
	);

	table_arbiter u_arbiter (
		.clk, .arst_n, .train_bus, .pred_bus,
		.en(tbl_en), .we(tbl_we), .addr(tbl_addr), .wdata(tbl_wdata), .rdata(tbl_rdata)
	);

	weight_table u_table (
		.clk, .arst_n,
		.en(tbl_en), .we(tbl_we), .addr(tbl_addr), .wdata(tbl_wdata), .rdata(tbl_rdata)
	);

	// no new request while either unit still owns its work
	assign busy = pred_active || train_active;

endmodule

/* verif/perceptron_tb.sv */
module perceptron_tb;

	localparam int hlen = perceptron_pkg::history_len;
	localparam int wait_limit = 40;

	logic clk;
	logic arst_n;
	logic predict_valid;
	logic [63:0] ip;
	logic resolve_valid;
	logic taken;
	logic pred_valid;
	logic pred_taken;
	logic signed [perceptron_pkg::sum_bits-1:0] pred_sum;
	logic busy;

	// golden model state and the record of the last prediction
	int weights [perceptron_pkg::row_count][hlen+1];
	logic [hlen-1:0] model_hist;
	int rec_idx;
	int rec_sum_m;
	logic [hlen-1:0] rec_hist_m;
	logic model_trained;
	int exp_sum;
	logic exp_taken;
	logic saw_taken;
	logic [31:0] lfsr;
	string test_name;
	int sum_errors;
	int taken_errors;
	int busy_errors;
	int reset_errors;
	int timeout_errors;
	int other_errors;

	perceptron_predictor DUT (
		.clk, .arst_n, .predict_valid, .ip, .resolve_valid, .taken,
		.pred_valid, .pred_taken, .pred_sum, .busy
	);

	initial begin
		clk = 1'b0;
		forever #50 clk = ~clk;
	end

	a_sum: assert property (@(posedge clk) disable iff (!arst_n) pred_valid |-> pred_sum == exp_sum)
	else begin
		sum_errors++;
		$display("mismatch %s sum expected %0d actual %0d", test_name, exp_sum, $sampled(pred_sum));
	end

	a_taken: assert property (@(posedge clk) disable iff (!arst_n)
		pred_valid |-> pred_taken == exp_taken)
	else begin
		taken_errors++;
		$display("mismatch %s taken expected %0b actual %0b", test_name, exp_taken,
			$sampled(pred_taken));
	end

	a_reset_idle: assert property (@(posedge clk) !arst_n |-> !busy && !pred_valid)
	else begin
		reset_errors++;
		$display("busy or pred_valid was high while reset was asserted in %s", test_name);
	end

	// Galois form, one step per bit taken
	function automatic logic [15:0] take_bits(input int n);
		logic [15:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[14:0], lfsr[0]};
			lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
		end
		return v;
	endfunction

	function automatic int model_sum(input int idx, input logic [hlen-1:0] h);
		int s;
		s = weights[idx][hlen];
		for (int i = 0; i < hlen; i++) begin
			s += h[i] ? weights[idx][i] : -weights[idx][i];
		end
		return s;
	endfunction

	function automatic int nudge(input int w, input logic up);
		if (up)
			return (w < 127) ? w + 1 : w;
		return (w > -127) ? w - 1 : w;
	endfunction

	task automatic model_resolve(input logic t);
		int mag;
		mag = (rec_sum_m < 0) ? -rec_sum_m : rec_sum_m;
		model_trained = ((rec_sum_m > 0) != t) || mag <= perceptron_pkg::threshold;
		if (model_trained) begin
			for (int i = 0; i < hlen; i++) begin
				weights[rec_idx][i] = nudge(weights[rec_idx][i], rec_hist_m[i] == t);
			end
			weights[rec_idx][hlen] = nudge(weights[rec_idx][hlen], t);
		end
		model_hist = {model_hist[hlen-2:0], t};
	endtask

	task automatic model_clear();
		foreach (weights[r, c]) weights[r][c] = 0;
		model_hist = '0;
	endtask

	task automatic wait_idle();
		int n;
		n = 0;
		while (busy && n < wait_limit) begin
			@(negedge clk);
			n++;
		end
		if (busy) begin
			timeout_errors++;
			$display("timeout in %s while waiting for busy to drop", test_name);
		end
	endtask

	task automatic wait_pred();
		int n;
		n = 0;
		while (!pred_valid && n < wait_limit) begin
			@(negedge clk);
			n++;
		end
		if (!pred_valid) begin
			timeout_errors++;
			$display("timeout in %s while waiting for pred_valid", test_name);
		end
	endtask

	// a predict, optionally paired in the same cycle with the resolve of the last one
	task automatic issue(input logic [63:0] addr, input logic with_resolve, input logic t);
		int s;
		logic [hlen-1:0] h;
		wait_idle();
		h = model_hist;
		s = model_sum(addr[7:0], h);
		predict_valid = 1'b1;
		ip = addr;
		resolve_valid = with_resolve;
		taken = t;
		// the paired prediction sees the table and history from before the resolve
		if (with_resolve)
			model_resolve(t);
		exp_sum = s;
		exp_taken = s > 0;
		rec_idx = addr[7:0];
		rec_sum_m = s;
		rec_hist_m = h;
		@(negedge clk);
		predict_valid = 1'b0;
		resolve_valid = 1'b0;
		wait_pred();
		if (pred_valid && pred_taken)
			saw_taken = 1'b1;
		wait_idle();
	endtask

	task automatic resolve(input logic t);
		int cycles;
		wait_idle();
		resolve_valid = 1'b1;
		taken = t;
		model_resolve(t);
		@(negedge clk);
		resolve_valid = 1'b0;
		// read grant, data and write grant when training, otherwise never busy
		cycles = 0;
		while (busy && cycles < wait_limit) begin
			@(negedge clk);
			cycles++;
		end
		a_busy_len: assert (cycles == (model_trained ? 3 : 0))
		else begin
			busy_errors++;
			$display("mismatch %s busy cycles expected %0d actual %0d", test_name,
				model_trained ? 3 : 0, cycles);
		end
		wait_idle();
	endtask

	task automatic cold_checks(input string name);
		logic [15:0] r;
		test_name = name;
		for (int k = 0; k < 8; k++) begin
			r = take_bits(16);
			issue({48'h0000_0040_2000, r}, 1'b0, 1'b0);
		end
	endtask

	task automatic run_reset();
		@(negedge clk);
		arst_n = 1'b0;
		model_clear();
		repeat (5) @(negedge clk);
		arst_n = 1'b1;
	endtask

	initial begin
		logic [15:0] r;
		logic [63:0] addr;
		predict_valid = 1'b0;
		resolve_valid = 1'b0;
		taken = 1'b0;
		ip = '0;
		exp_sum = 0;
		exp_taken = 1'b0;
		saw_taken = 1'b0;
		model_trained = 1'b0;
		lfsr = 32'h9601;
		sum_errors = 0;
		taken_errors = 0;
		busy_errors = 0;
		reset_errors = 0;
		timeout_errors = 0;
		other_errors = 0;
		test_name = "reset";
		arst_n = 1'b0;
		model_clear();
		repeat (5) @(negedge clk);
		arst_n = 1'b1;

		cold_checks("cold_start");

		test_name = "learning";
		saw_taken = 1'b0;
		for (int k = 0; k < 20; k++) begin
			issue(64'h0000_0000_0040_1040, 1'b0, 1'b0);
			resolve(1'b1);
		end
		if (!saw_taken) begin
			other_errors++;
			$display("learning run never saw the DUT predict taken");
		end

		test_name = "independence";
		for (int k = 0; k < 6; k++) begin
			issue(64'h0000_0000_0040_1041, 1'b0, 1'b0);
			resolve(1'b0);
		end
		issue(64'h0000_0000_0040_1040, 1'b0, 1'b0);

		test_name = "saturation";
		for (int k = 0; k < 150; k++) begin
			issue(64'h0000_0000_0040_10c3, 1'b0, 1'b0);
			resolve(1'b1);
		end

		// few distinct rows so that training and reads collide often
		test_name = "random_mix";
		for (int k = 0; k < 80; k++) begin
			r = take_bits(3);
			addr = {56'h00_0000_0040_1000_00, 5'b01010, r[2:0]};
			r = take_bits(2);
			if (r[1:0] == 2'd0) begin
				r = take_bits(1);
				issue(addr, 1'b1, r[0]);
			end else begin
				r = take_bits(1);
				resolve(r[0]);
				issue(addr, 1'b0, 1'b0);
			end
		end

		test_name = "reset_midrun";
		run_reset();
		cold_checks("reset_midrun");

		repeat (3) @(negedge clk);
		$display("errors: sum %0d, taken %0d, busy %0d, reset %0d, timeout %0d, other %0d",
			sum_errors, taken_errors, busy_errors, reset_errors, timeout_errors, other_errors);
		if (sum_errors + taken_errors + busy_errors + reset_errors + timeout_errors
			+ other_errors == 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

endmodule

/* list.f */
logic/perceptron_pkg.sv
logic/weight_bus_if.sv
logic/weight_table.sv
logic/table_arbiter.sv
logic/predict_unit.sv
logic/train_unit.sv
logic/perceptron_predictor.sv
verif/perceptron_tb.sv

/* Makefile */
VERILATOR = verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = perceptron_tb
FILELIST = list.f
BUILD_DIR = obj_dir
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run the testbench and check the log"
	@echo "  clean  remove the build folder and the log"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "TB FAILED" $(LOG); then exit 1; fi
	@grep -q "TB PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
